//--- sim.f
+incdir+hdl
hdl/iopage_pkg.sv
hdl/iopage_decode.sv
hdl/parallel_port.sv
hdl/iopage_rdmux.sv
hdl/intr_arbiter.sv
hdl/iopage.sv
tests/tb_iopage.sv

//--- tests/tb_iopage.sv
/*
 * I/O page testbench with a register and arbiter model
 * random register traffic, decode, pulse and interrupt checks
 */
`default_nettype none
`timescale 1ns/100ps
`include "iopage_config.svh"

module tb_iopage;

   import iopage_pkg::*;

   localparam int          NP    = `IOPAGE_NUM_PORTS;
   localparam int          NSRC  = 2 * NP;
   localparam logic [12:0] BASE  = `IOPAGE_PORT_BASE;
   localparam logic [7:0]  VBASE = `IOPAGE_VEC_BASE;

   logic        clk;
   logic        arst_n;
   logic [12:0] address;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic        byte_op;
   logic [15:0] data_out;
   logic        no_decode;
   port_in_t    pins [NP];
   port_out_t   pouts [NP];
   logic        interrupt;
   logic [7:0]  vector;
   logic        interrupt_ack;

   // register model per port
   logic        m_ie_a [NP];
   logic        m_ie_b [NP];
   logic [1:0]  m_fnct [NP];
   logic [15:0] m_outbuf [NP];

   int errors;
   int checks;

   iopage u_dut (
      .clk            (clk),
      .arst_n         (arst_n),
      .address        (address),
      .data_in        (data_in),
      .iopage_rd      (rd),
      .iopage_wr      (wr),
      .iopage_byte_op (byte_op),
      .data_out       (data_out),
      .no_decode      (no_decode),
      .port_pins_in   (pins),
      .port_pins_out  (pouts),
      .interrupt      (interrupt),
      .vector         (vector),
      .interrupt_ack  (interrupt_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[FAIL] %s: expected 'h%0h, actual 'h%0h", name, exp, act);
      end
   endtask

   function automatic logic [12:0] reg_addr(input int p, input int off, input bit odd);
      return BASE + 13'(8 * p + 2 * off + int'(odd));
   endfunction

   // CSR holds REQ B at 15, REQ A at 7, enables at 6 and 5, function at 1:0
   function automatic logic [15:0] exp_csr(input int p);
      return {pins[p].req_b, 7'b0, pins[p].req_a, m_ie_a[p], m_ie_b[p], 3'b0, m_fnct[p]};
   endfunction

   // called on a falling edge, returns on the next one with strobes low
   task automatic do_write(input int p, input int off, input bit bop, input bit odd,
                           input logic [15:0] d);
      address = reg_addr(p, off, odd);
      data_in = d;
      byte_op = bop;
      wr      = 1'b1;
      if (off == 0 && (!bop || !odd))
      begin
         m_ie_a[p] = d[6];
         m_ie_b[p] = d[5];
         m_fnct[p] = d[1:0];
      end
      if (off == 1 && (!bop || !odd))
         m_outbuf[p][7:0] = d[7:0];
      if (off == 1 && (!bop || odd))
         m_outbuf[p][15:8] = d[15:8];
      @(negedge clk);
      wr      = 1'b0;
      byte_op = 1'b0;
   endtask

   task automatic read_at(input logic [12:0] a, output logic [15:0] d, output logic nd);
      address = a;
      rd      = 1'b1;
      #1;
      d  = data_out;
      nd = no_decode;
      @(negedge clk);
      rd = 1'b0;
   endtask

   task automatic reset_dut();
      interrupt_ack = 1'b0;
      for (int i = 0; i < NP; i++)
      begin
         pins[i]     = '0;
         m_ie_a[i]   = 1'b0;
         m_ie_b[i]   = 1'b0;
         m_fnct[i]   = 2'b00;
         m_outbuf[i] = '0;
      end
      arst_n = 1'b0;
      repeat (3) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic check_reset_state();
      logic [15:0] rdat;
      logic        nd;
      check("interrupt after reset", 0, interrupt);
      for (int i = 0; i < NP; i++)
      begin
         check("new_data_ready after reset", 0, pouts[i].new_data_ready);
         check("data_transmitted after reset", 0, pouts[i].data_transmitted);
         read_at(reg_addr(i, 0, 0), rdat, nd);
         check("CSR after reset", 0, rdat);
         read_at(reg_addr(i, 1, 0), rdat, nd);
         check("OUTBUF after reset", 0, rdat);
      end
   endtask

   task automatic wait_interrupt(output bit ok);
      int n;
      n = 0;
      while (!interrupt && n < 40)
      begin
         @(negedge clk);
         n++;
      end
      ok = interrupt;
      if (!ok)
      begin
         errors++;
         $display("timeout: interrupt did not rise within 40 cycles");
      end
   endtask

   task automatic ack_interrupt();
      interrupt_ack = 1'b1;
      @(negedge clk);
      interrupt_ack = 1'b0;
      check("interrupt low after ack", 0, interrupt);
   endtask

   initial
   begin
      int              p;
      int              off;
      int              idx;
      bit              bop;
      bit              odd;
      bit              wrote;
      bit              ok;
      logic [15:0]     rdat;
      logic            nd;
      logic [12:0]     a;
      logic [NSRC-1:0] pend;

      errors = 0;
      checks = 0;
      void'($urandom(46936));
      arst_n        = 1'b0;
      address       = '0;
      data_in       = '0;
      rd            = 1'b0;
      wr            = 1'b0;
      byte_op       = 1'b0;
      interrupt_ack = 1'b0;
      for (int i = 0; i < NP; i++)
         pins[i] = '0;

      reset_dut();
      check_reset_state();

      // random register traffic with pin changes
      repeat (400)
      begin
         p = int'($urandom % NP);
         if ($urandom % 4 == 0)
         begin
            pins[p].inbuf = 16'($urandom);
            pins[p].req_a = 1'($urandom);
            pins[p].req_b = 1'($urandom);
         end
         off   = int'($urandom % 3);
         wrote = 1'($urandom);
         if (wrote)
         begin
            bop = 1'($urandom);
            odd = bop ? 1'($urandom) : 1'b0;
            do_write(p, off, bop, odd, 16'($urandom));
         end
         else
         begin
            read_at(reg_addr(p, off, 0), rdat, nd);
            check("no_decode inside window", 0, nd);
            if (off == 0)
               check("CSR read", exp_csr(p), rdat);
            else if (off == 1)
               check("OUTBUF read", m_outbuf[p], rdat);
            else
               check("INBUF read", pins[p].inbuf, rdat);
         end
         check("new_data_ready", wrote && off == 1, pouts[p].new_data_ready);
         check("data_transmitted", !wrote && off == 2, pouts[p].data_transmitted);
         check("outbuf pins", m_outbuf[p], pouts[p].outbuf);
         check("function pins", m_fnct[p], pouts[p].fnct);
      end

      // unclaimed addresses below the bank and offset 3
      repeat (100)
      begin
         if ($urandom % 2)
            a = 13'($urandom % BASE);
         else
            a = reg_addr(int'($urandom % NP), 3, 1'($urandom));
         read_at(a, rdat, nd);
         check("unclaimed read data", 0, rdat);
         check("unclaimed no_decode", 1, nd);
      end

      reset_dut();
      check_reset_state();

      // single requests
      repeat (20)
      begin
         p   = int'($urandom % NP);
         odd = 1'($urandom);
         do_write(p, 0, 1'b0, 1'b0, odd ? 16'h0020 : 16'h0040);
         if (odd)
            pins[p].req_b = 1'b1;
         else
            pins[p].req_a = 1'b1;
         wait_interrupt(ok);
         if (ok)
         begin
            check("single vector", VBASE + 8'(8 * p + 4 * int'(odd)), vector);
            ack_interrupt();
         end
         pins[p].req_a = 1'b0;
         pins[p].req_b = 1'b0;
         do_write(p, 0, 1'b0, 1'b0, 16'h0000);
      end

      // several pending at once, served lowest source first
      for (int i = 0; i < NP; i++)
         do_write(i, 0, 1'b0, 1'b0, 16'h0060);
      repeat (15)
      begin
         pend = NSRC'($urandom);
         if (pend == '0)
            pend[0] = 1'b1;
         for (int i = 0; i < NP; i++)
         begin
            pins[i].req_a = pend[2 * i];
            pins[i].req_b = pend[2 * i + 1];
         end
         while (pend != '0)
         begin
            idx = 0;
            for (int s = NSRC - 1; s >= 0; s--)
               if (pend[s])
                  idx = s;
            wait_interrupt(ok);
            if (!ok)
               pend = '0;
            else
            begin
               // source idx is port idx/2, request B when idx is odd
               check("priority vector", VBASE + 8'(8 * (idx / 2) + 4 * (idx % 2)), vector);
               ack_interrupt();
               pend[idx] = 1'b0;
            end
         end
         for (int i = 0; i < NP; i++)
         begin
            pins[i].req_a = 1'b0;
            pins[i].req_b = 1'b0;
         end
         @(negedge clk);
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/iopage.sv
/*
 * I/O page top level
 * decoder, parallel port bank, read mux and interrupt arbiter
 */
`default_nettype none
`timescale 1ns/100ps
`include "iopage_config.svh"

module iopage
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic [12:0]            address,
   input  logic [15:0]            data_in,
   input  logic                   iopage_rd,
   input  logic                   iopage_wr,
   input  logic                   iopage_byte_op,
   output logic [15:0]            data_out,
   output logic                   no_decode,
   input  iopage_pkg::port_in_t   port_pins_in  [`IOPAGE_NUM_PORTS],
   output iopage_pkg::port_out_t  port_pins_out [`IOPAGE_NUM_PORTS],
   output logic                   interrupt,
   output logic [7:0]             vector,
   input  logic                   interrupt_ack
);

   import iopage_pkg::*;

   localparam int unsigned NUM_PORTS = `IOPAGE_NUM_PORTS;

   iop_req_t               req;
   logic [NUM_PORTS-1:0]   sel;
   logic [1:0]             reg_off;
   port_rsp_t              rsp [NUM_PORTS];
   logic [2*NUM_PORTS-1:0] irq;
   logic [2*NUM_PORTS-1:0] irq_ack;

   assign req.addr    = address;
   assign req.wdata   = data_in;
   assign req.rd      = iopage_rd;
   assign req.wr      = iopage_wr;
   assign req.byte_op = iopage_byte_op;

   iopage_decode u_decode (
      .clk     (clk),
      .arst_n  (arst_n),
      .req     (req),
      .sel     (sel),
      .reg_off (reg_off)
   );

   // port n owns irq bits 2n (A) and 2n+1 (B)
   for (genvar i = 0; i < NUM_PORTS; i++)
   begin : g_port
      parallel_port u_port (
         .clk      (clk),
         .arst_n   (arst_n),
         .sel      (sel[i]),
         .reg_off  (reg_off),
         .req      (req),
         .pins_in  (port_pins_in[i]),
         .pins_out (port_pins_out[i]),
         .rsp      (rsp[i]),
         .irq      (irq[2*i +: 2]),
         .irq_ack  (irq_ack[2*i +: 2])
      );
   end

   iopage_rdmux u_rdmux (
      .rsp       (rsp),
      .rd        (iopage_rd),
      .wr        (iopage_wr),
      .data_out  (data_out),
      .no_decode (no_decode)
   );

   intr_arbiter u_arbiter (
      .clk           (clk),
      .arst_n        (arst_n),
      .irq           (irq),
      .interrupt     (interrupt),
      .vector        (vector),
      .interrupt_ack (interrupt_ack),
      .irq_ack       (irq_ack)
   );

endmodule

`default_nettype wire

//--- hdl/intr_arbiter.sv
/*
 * fixed-priority interrupt arbiter
 * holds the granted vector until the CPU acknowledges
 */
`default_nettype none
`timescale 1ns/100ps
`include "iopage_config.svh"

module intr_arbiter
(
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic [2*`IOPAGE_NUM_PORTS-1:0]  irq,
   output logic                            interrupt,
   output logic [7:0]                      vector,
   input  logic                            interrupt_ack,
   output logic [2*`IOPAGE_NUM_PORTS-1:0]  irq_ack
);

   localparam int unsigned NUM_SRC  = 2 * `IOPAGE_NUM_PORTS;
   localparam int unsigned IDX_W    = $clog2(NUM_SRC);
   localparam logic [7:0]  VEC_BASE = `IOPAGE_VEC_BASE;

   logic             pick_valid;
   logic [IDX_W-1:0] pick_idx;
   logic [IDX_W-1:0] grant_idx;

   // lowest index wins in the order port 0 A, port 0 B, port 1 A ...
   always_comb
   begin
      pick_valid = 1'b0;
      pick_idx   = '0;
      for (int s = NUM_SRC - 1; s >= 0; s--)
      begin
         if (irq[s])
         begin
            pick_valid = 1'b1;
            pick_idx   = IDX_W'(s);
         end
      end
   end

   // after an ack interrupt stays low one cycle, which lets the
   // acked request clear before the next pick
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         interrupt <= 1'b0;
         grant_idx <= '0;
         vector    <= '0;
      end
      else if (interrupt)
      begin
         if (interrupt_ack)
            interrupt <= 1'b0;
      end
      else if (pick_valid)
      begin
         interrupt <= 1'b1;
         grant_idx <= pick_idx;
         // 4 bytes per source
         vector    <= VEC_BASE + (8'(pick_idx) << 2);
      end
   end

   always_comb
   begin
      irq_ack = '0;
      if (interrupt && interrupt_ack)
         irq_ack[grant_idx] = 1'b1;
   end

   a_vec_stable : assert property (
      @(posedge clk) disable iff (!arst_n)
      (interrupt && !interrupt_ack) |=> interrupt && $stable(vector)
   ) else $error("vector changed while interrupt held");

endmodule

`default_nettype wire

//--- hdl/iopage_rdmux.sv
/*
 * I/O page read multiplexer
 * merges port read data and flags unclaimed cycles
 */
`default_nettype none
`timescale 1ns/100ps
`include "iopage_config.svh"

module iopage_rdmux
(
   input  iopage_pkg::port_rsp_t  rsp [`IOPAGE_NUM_PORTS],
   input  logic                   rd,
   input  logic                   wr,
   output logic [15:0]            data_out,
   output logic                   no_decode
);

   localparam int unsigned NUM_PORTS = `IOPAGE_NUM_PORTS;

   logic [NUM_PORTS-1:0] hits;

   // unclaimed cycles read as zero
   always_comb
   begin
      data_out = '0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         hits[i] = rsp[i].hit;
         if (rsp[i].hit)
            data_out = rsp[i].rdata;
      end
   end

   assign no_decode = (rd || wr) && !(|hits);

   // windows never overlap, so two hits means a decode fault
   always_comb
   begin
      a_one_hit : assert final ($onehot0(hits))
         else $error("more than one port claimed the cycle");
   end

endmodule

`default_nettype wire

//--- hdl/parallel_port.sv
/*
 * DR11-C style parallel interface
 * CSR, output buffer, input buffer and two interrupt requests
 */
`default_nettype none
`timescale 1ns/100ps

module parallel_port
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   sel,
   input  logic [1:0]             reg_off,
   input  iopage_pkg::iop_req_t   req,
   input  iopage_pkg::port_in_t   pins_in,
   output iopage_pkg::port_out_t  pins_out,
   output iopage_pkg::port_rsp_t  rsp,
   output logic [1:0]             irq,
   input  logic [1:0]             irq_ack
);

   localparam logic [1:0] OFF_CSR    = 2'd0;
   localparam logic [1:0] OFF_OUTBUF = 2'd1;
   localparam logic [1:0] OFF_INBUF  = 2'd2;

   logic        ie_a;
   logic        ie_b;
   logic [1:0]  fnct;
   logic [15:0] outbuf;
   logic        lo_wr;
   logic        hi_wr;
   logic        csr_wr;
   logic        outbuf_wr;
   logic        inbuf_rd;
   logic [15:0] csr_rd;
   logic        cond_a;
   logic        cond_b;
   logic        cond_a_d;
   logic        cond_b_d;
   logic        new_data_ready;
   logic        data_transmitted;

   // even address takes the low byte, odd the high byte
   assign lo_wr = req.wr && (!req.byte_op || !req.addr[0]);
   assign hi_wr = req.wr && (!req.byte_op || req.addr[0]);

   assign csr_wr    = sel && (reg_off == OFF_CSR);
   assign outbuf_wr = sel && (reg_off == OFF_OUTBUF) && req.wr;
   assign inbuf_rd  = sel && (reg_off == OFF_INBUF) && req.rd;

   // only the low byte of the CSR is writable
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ie_a   <= 1'b0;
         ie_b   <= 1'b0;
         fnct   <= 2'b00;
         outbuf <= '0;
      end
      else
      begin
         if (csr_wr && lo_wr)
         begin
            ie_a <= req.wdata[6];
            ie_b <= req.wdata[5];
            fnct <= req.wdata[1:0];
         end
         if (outbuf_wr && lo_wr)
            outbuf[7:0] <= req.wdata[7:0];
         if (outbuf_wr && hi_wr)
            outbuf[15:8] <= req.wdata[15:8];
      end
   end

   // interrupts are edge triggered on req & enable
   assign cond_a = pins_in.req_a && ie_a;
   assign cond_b = pins_in.req_b && ie_b;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cond_a_d         <= 1'b0;
         cond_b_d         <= 1'b0;
         irq              <= 2'b00;
         new_data_ready   <= 1'b0;
         data_transmitted <= 1'b0;
      end
      else
      begin
         cond_a_d         <= cond_a;
         cond_b_d         <= cond_b;
         new_data_ready   <= outbuf_wr;
         data_transmitted <= inbuf_rd;

         if (!ie_a)
            irq[0] <= 1'b0;
         else if (cond_a && !cond_a_d)
            irq[0] <= 1'b1;
         else if (irq_ack[0])
            irq[0] <= 1'b0;

         if (!ie_b)
            irq[1] <= 1'b0;
         else if (cond_b && !cond_b_d)
            irq[1] <= 1'b1;
         else if (irq_ack[1])
            irq[1] <= 1'b0;
      end
   end

   // REQ B and REQ A show the live pin levels
   assign csr_rd = {pins_in.req_b, 7'b0, pins_in.req_a, ie_a, ie_b, 3'b0, fnct};

   always_comb
   begin
      rsp.hit   = sel && (reg_off != 2'd3);
      rsp.rdata = '0;
      if (sel)
      begin
         case (reg_off)
            OFF_CSR:    rsp.rdata = csr_rd;
            OFF_OUTBUF: rsp.rdata = outbuf;
            OFF_INBUF:  rsp.rdata = pins_in.inbuf;
            default:    rsp.rdata = '0;
         endcase
      end
   end

   assign pins_out.outbuf           = outbuf;
   assign pins_out.fnct             = fnct;
   assign pins_out.new_data_ready   = new_data_ready;
   assign pins_out.data_transmitted = data_transmitted;

   // arbiter acks only what this port still has pending
   a_ack_pending : assert property (
      @(posedge clk) disable iff (!arst_n)
      ((irq_ack & {ie_b, ie_a} & ~irq) == 2'b00)
   ) else $error("ack for a request that is not pending");

   // writes to offset 3 leave every register alone
   a_off3_ignored : assert property (
      @(posedge clk) disable iff (!arst_n)
      (sel && req.wr && reg_off == 2'd3) |=>
         $stable(outbuf) && $stable(fnct) && $stable({ie_a, ie_b})
   ) else $error("write to undefined offset changed a register");

endmodule

`default_nettype wire

//--- hdl/iopage_decode.sv
/*
 * I/O page address decoder
 * one-hot port select and register word offset
 */
`default_nettype none
`timescale 1ns/100ps
`include "iopage_config.svh"

module iopage_decode
(
   input  logic                          clk,
   input  logic                          arst_n,
   input  iopage_pkg::iop_req_t          req,
   output logic [`IOPAGE_NUM_PORTS-1:0]  sel,
   output logic [1:0]                    reg_off
);

   localparam int unsigned NUM_PORTS = `IOPAGE_NUM_PORTS;
   localparam logic [12:0] PORT_BASE = `IOPAGE_PORT_BASE;
   localparam int unsigned WIN_BYTES = 2 * `IOPAGE_WIN_WORDS;

   // elaboration checks on the configured bank
   generate
      if (NUM_PORTS < 1 || NUM_PORTS > 8)
      begin : g_bad_count
         $error("port count must be between 1 and 8");
      end

      if (PORT_BASE + 13'(WIN_BYTES * (NUM_PORTS - 1)) != 13'o7770)
      begin : g_bad_base
         $error("last port window must sit at octal 7770");
      end
   endgenerate

   // one 8-byte window per port, consecutive upward from the base
   generate
      for (genvar i = 0; i < NUM_PORTS; i++)
      begin : g_win
         localparam logic [12:0] WIN = PORT_BASE + 13'(WIN_BYTES * i);

         assign sel[i] = (req.addr[12:3] == WIN[12:3]);
      end
   endgenerate

   // word within the window with the byte lane in addr[0]
   assign reg_off = req.addr[2:1];

   // the CPU never reads and writes in one cycle
   a_rd_wr_excl : assert property (
      @(posedge clk) disable iff (!arst_n)
      !(req.rd && req.wr)
   ) else $error("rd and wr both high");

endmodule

`default_nettype wire

//--- hdl/iopage_pkg.sv
/*
 * shared types of the I/O page
 * bus cycle, port pin bundles and port read response
 */
`default_nettype none

package iopage_pkg;

   // one cycle on the I/O page bus
   typedef struct packed {
      logic [12:0] addr;
      logic [15:0] wdata;
      logic        rd;
      logic        wr;
      logic        byte_op;
   } iop_req_t;

   // pins driven into one parallel port
   typedef struct packed {
      logic [15:0] inbuf;
      logic        req_a;
      logic        req_b;
   } port_in_t;

   // pins driven out of one parallel port
   typedef struct packed {
      logic [15:0] outbuf;
      logic [1:0]  fnct;
      logic        new_data_ready;
      logic        data_transmitted;
   } port_out_t;

   // read data of one port, hit set when it claims the cycle
   typedef struct packed {
      logic [15:0] rdata;
      logic        hit;
   } port_rsp_t;

endpackage

`default_nettype wire

//--- hdl/iopage_config.svh
/*
 * build-time sizing of the I/O page port bank
 * port count, port window base and first interrupt vector
 */
`ifndef IOPAGE_CONFIG_SVH
`define IOPAGE_CONFIG_SVH

// number of parallel ports from 1 to 8
`define IOPAGE_NUM_PORTS 4

// port 0 window with the last port at octal 7770
`define IOPAGE_PORT_BASE (13'o7770 - 13'(8 * (`IOPAGE_NUM_PORTS - 1)))

// port n uses base + 8n for request A and base + 8n + 4 for request B
`define IOPAGE_VEC_BASE 8'o300

// registers per port window, in words
`define IOPAGE_WIN_WORDS 4

`endif
